// ==== hdl/bp_pkg.sv ====
/*
 * Branch predictor shared definitions.
 * Holds the row geometry of the branch history table, the encoding of the
 * 2-bit saturating counter and the row union that lets the memory see a row
 * as raw bits while the predict and update logic see it as counters.
 */
package bp_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Row geometry.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int bp_row_els   = 2;                          // Counters per row.
  localparam int bp_ctr_width = 2;                          // Bits per counter.
  localparam int bp_row_width = bp_row_els * bp_ctr_width;  // Bits per row.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Counter encoding.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // The high bit is the predicted direction, the low bit marks a weak state.
  typedef logic [bp_ctr_width-1:0] bp_ctr_t;

  localparam int bp_ctr_dir_bit  = 1;  // Set means predict taken.
  localparam int bp_ctr_weak_bit = 0;  // Set means weak state.

  // Weakly not-taken, written to every counter while the table clears.
  localparam bp_ctr_t bp_ctr_init = 2'b01;

  // One table row, either as a plain word or as its counters.
  typedef union packed {
    logic [bp_row_width-1:0]        raw;
    bp_ctr_t [bp_row_els-1:0]       ctr;
  } bp_row_u;

endpackage

// ==== hdl/bht_mem.sv ====
/*
 * Branch history table storage.
 * One read port and one write port, both synchronous. The read data is
 * registered and held until the next read is issued.
 */
`timescale 1ns/1ps

module bht_mem
  import bp_pkg::*;
#(
  parameter int width_p = bp_row_width,
  parameter int els_p   = 64,
  localparam int addr_width_lp = $clog2(els_p)
)
(
  input  logic                     clk_i,

  input  logic                     w_v_i,
  input  logic [addr_width_lp-1:0] w_addr_i,
  input  bp_row_u                  w_data_i,

  input  logic                     r_v_i,
  input  logic [addr_width_lp-1:0] r_addr_i,
  output bp_row_u                  r_data_o
);

  logic [width_p-1:0] mem_r [els_p];  // Row storage.

  // Write port.
  always_ff @(posedge clk_i)
  begin
    if (w_v_i)
    begin
      mem_r[w_addr_i] <= w_data_i.raw;
    end
  end

  // Read port. The output keeps the last row read when r_v_i is low.
  always_ff @(posedge clk_i)
  begin
    if (r_v_i)
    begin
      r_data_o.raw <= mem_r[r_addr_i];
    end
  end

endmodule

// ==== hdl/bht.sv ====
/*
 * Gselect branch history table.
 * Clears every row to weakly not-taken after reset, then serves lookups
 * indexed by address bits and global history. Writes apply the saturating
 * counter rule to a whole row and are refused while a lookup in the same
 * cycle hits the same index.
 */
`timescale 1ns/1ps

module bht
  import bp_pkg::*;
#(
  parameter int bht_idx_width_p = 4,
  parameter int ghist_width_p   = 2,
  parameter int vaddr_width_p   = 32
)
(
  input  logic                       clk_i,
  input  logic                       reset_i,

  output logic                       init_done_o,

  input  logic                       w_v_i,
  input  logic [bht_idx_width_p-1:0] w_idx_i,
  input  logic [ghist_width_p-1:0]   w_ghist_i,
  input  bp_row_u                    w_row_i,
  input  logic                       w_correct_i,
  output logic                       w_yumi_o,

  input  logic                       r_v_i,
  input  logic [vaddr_width_p-1:0]   r_addr_i,
  input  logic [ghist_width_p-1:0]   r_ghist_i,
  output bp_row_u                    r_row_o,
  output logic                       r_taken_o,
  output logic [ghist_width_p-1:0]   r_ghist_o
);

  localparam int idx_width_lp = bht_idx_width_p + ghist_width_p;
  localparam int els_lp       = 2**idx_width_lp;
  localparam int slot_bit_lp  = 2 + bht_idx_width_p;  // Picks the counter in a row.

  localparam logic [1:0] st_reset = 2'd0;
  localparam logic [1:0] st_clear = 2'd1;
  localparam logic [1:0] st_run   = 2'd2;

  logic [1:0]              state_r, state_n;
  logic [idx_width_lp-1:0] clr_cnt_r;
  logic                    is_clear, is_run, clr_last;

  logic [idx_width_lp-1:0] r_idx, w_idx, mem_w_addr;
  logic                    rw_same_idx, mem_w_v;
  bp_row_u                 mem_w_data, mem_r_data;

  logic                     slot_r;
  logic [ghist_width_p-1:0] ghist_r;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Clear sequencer. One row per cycle, then normal operation.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign is_clear    = (state_r == st_clear);
  assign is_run      = (state_r == st_run);
  assign clr_last    = (clr_cnt_r == idx_width_lp'(els_lp - 1));
  assign init_done_o = is_run;

  always_comb
  begin
    case (state_r)
      st_clear: state_n = clr_last ? st_run : st_clear;
      st_run:   state_n = st_run;
      default:  state_n = st_clear;  // Leaving reset starts the clear.
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r   <= st_reset;
      clr_cnt_r <= '0;
    end
    else
    begin
      state_r <= state_n;
      if (is_clear)
      begin
        clr_cnt_r <= clr_cnt_r + 1'b1;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Gselect indexing and write arbitration.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign r_idx = {r_addr_i[2 +: bht_idx_width_p], r_ghist_i};
  assign w_idx = {w_idx_i, w_ghist_i};

  // A lookup always wins over a write to the same row.
  assign rw_same_idx = r_v_i & w_v_i & (r_idx == w_idx);
  assign w_yumi_o    = is_run & w_v_i & ~rw_same_idx;

  assign mem_w_v    = is_clear | w_yumi_o;
  assign mem_w_addr = is_clear ? clr_cnt_r : w_idx;

  // Counter update. Weak bit follows a miss, direction flips on a weak miss.
  always_comb
  begin
    for (int i = 0; i < bp_row_els; i++)
    begin
      if (is_clear)
      begin
        mem_w_data.ctr[i] = bp_ctr_init;
      end
      else
      begin
        mem_w_data.ctr[i][bp_ctr_weak_bit] = ~w_correct_i;
        mem_w_data.ctr[i][bp_ctr_dir_bit]  = w_row_i.ctr[i][bp_ctr_dir_bit]
                                             ^ (~w_correct_i & w_row_i.ctr[i][bp_ctr_weak_bit]);
      end
    end
  end

  bht_mem #(
    .width_p (bp_row_width),
    .els_p   (els_lp)
  ) i_bht_mem (
    .clk_i    (clk_i),
    .w_v_i    (mem_w_v),
    .w_addr_i (mem_w_addr),
    .w_data_i (mem_w_data),
    .r_v_i    (r_v_i),
    .r_addr_i (r_idx),
    .r_data_o (mem_r_data)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Prediction. Slot and history are held alongside the read data.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk_i)
  begin
    if (r_v_i)
    begin
      slot_r  <= r_addr_i[slot_bit_lp];
      ghist_r <= r_ghist_i;
    end
  end

  assign r_row_o   = mem_r_data;
  assign r_taken_o = mem_r_data.ctr[slot_r][bp_ctr_dir_bit];
  assign r_ghist_o = ghist_r;

endmodule

// ==== hdl/bp_update_ctrl.sv ====
/*
 * Branch resolution buffer.
 * Holds one resolved branch, offers it to the history table until the table
 * takes it, and keeps the non-speculative global history.
 */
`timescale 1ns/1ps

module bp_update_ctrl
  import bp_pkg::*;
#(
  parameter int bht_idx_width_p = 4,
  parameter int ghist_width_p   = 2,
  parameter int vaddr_width_p   = 32
)
(
  input  logic                       clk_i,
  input  logic                       reset_i,

  input  logic                       res_v_i,
  input  logic [vaddr_width_p-1:0]   res_addr_i,
  input  logic [ghist_width_p-1:0]   res_ghist_i,
  input  bp_row_u                    res_row_i,
  input  logic                       res_correct_i,
  input  logic                       res_taken_i,
  output logic                       res_ready_o,

  output logic                       w_v_o,
  output logic [bht_idx_width_p-1:0] w_idx_o,
  output logic [ghist_width_p-1:0]   w_ghist_o,
  output bp_row_u                    w_row_o,
  output logic                       w_correct_o,
  input  logic                       w_yumi_i,

  output logic [ghist_width_p-1:0]   ghist_o
);

  logic                       full_r;      // Buffer holds a resolution.
  logic                       res_fire;
  logic [bht_idx_width_p-1:0] idx_r;
  logic [ghist_width_p-1:0]   res_ghist_r; // History seen by the original lookup.
  logic [ghist_width_p-1:0]   ghist_r;
  bp_row_u                    row_r;
  logic                       correct_r;
  logic                       taken_r;

  assign res_ready_o = ~full_r;
  assign res_fire    = res_v_i & res_ready_o;

  // Buffer state and global history. Newest outcome enters at bit 0.
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      full_r  <= 1'b0;
      ghist_r <= '0;
    end
    else
    begin
      if (res_fire)
        full_r <= 1'b1;
      else if (w_yumi_i)
        full_r <= 1'b0;
      if (w_yumi_i)
        ghist_r <= {ghist_r[ghist_width_p-2:0], taken_r};
    end
  end

  // Buffered resolution.
  always_ff @(posedge clk_i)
  begin
    if (res_fire)
    begin
      idx_r       <= res_addr_i[2 +: bht_idx_width_p];
      res_ghist_r <= res_ghist_i;
      row_r       <= res_row_i;
      correct_r   <= res_correct_i;
      taken_r     <= res_taken_i;
    end
  end

  assign w_v_o       = full_r;
  assign w_idx_o     = idx_r;
  assign w_ghist_o   = res_ghist_r;
  assign w_row_o     = row_r;
  assign w_correct_o = correct_r;
  assign ghist_o     = ghist_r;

endmodule

// ==== hdl/bp_predictor.sv ====
/*
 * Branch direction predictor.
 * Joins the resolution buffer and the gselect history table. Lookups read
 * the table with the current global history, resolutions update it.
 */
`timescale 1ns/1ps

module bp_predictor
  import bp_pkg::*;
#(
  parameter int bht_idx_width_p = 4,
  parameter int ghist_width_p   = 2,
  parameter int vaddr_width_p   = 32
)
(
  input  logic                     clk_i,
  input  logic                     reset_i,

  output logic                     init_done_o,

  // Lookup.
  input  logic                     pred_v_i,
  input  logic [vaddr_width_p-1:0] pred_addr_i,
  output bp_row_u                  pred_row_o,
  output logic                     pred_taken_o,
  output logic [ghist_width_p-1:0] pred_ghist_o,

  // Resolution.
  input  logic                     res_v_i,
  input  logic [vaddr_width_p-1:0] res_addr_i,
  input  logic [ghist_width_p-1:0] res_ghist_i,
  input  bp_row_u                  res_row_i,
  input  logic                     res_correct_i,
  input  logic                     res_taken_i,
  output logic                     res_ready_o,

  output logic [ghist_width_p-1:0] ghist_o
);

  logic                       w_v;
  logic [bht_idx_width_p-1:0] w_idx;
  logic [ghist_width_p-1:0]   w_ghist;
  bp_row_u                    w_row;
  logic                       w_correct;
  logic                       w_yumi;

  bp_update_ctrl #(
    .bht_idx_width_p (bht_idx_width_p),
    .ghist_width_p   (ghist_width_p),
    .vaddr_width_p   (vaddr_width_p)
  ) i_bp_update_ctrl (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .res_v_i       (res_v_i),
    .res_addr_i    (res_addr_i),
    .res_ghist_i   (res_ghist_i),
    .res_row_i     (res_row_i),
    .res_correct_i (res_correct_i),
    .res_taken_i   (res_taken_i),
    .res_ready_o   (res_ready_o),
    .w_v_o         (w_v),
    .w_idx_o       (w_idx),
    .w_ghist_o     (w_ghist),
    .w_row_o       (w_row),
    .w_correct_o   (w_correct),
    .w_yumi_i      (w_yumi),
    .ghist_o       (ghist_o)
  );

  // Lookups index with the committed history.
  bht #(
    .bht_idx_width_p (bht_idx_width_p),
    .ghist_width_p   (ghist_width_p),
    .vaddr_width_p   (vaddr_width_p)
  ) i_bht (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .init_done_o (init_done_o),
    .w_v_i       (w_v),
    .w_idx_i     (w_idx),
    .w_ghist_i   (w_ghist),
    .w_row_i     (w_row),
    .w_correct_i (w_correct),
    .w_yumi_o    (w_yumi),
    .r_v_i       (pred_v_i),
    .r_addr_i    (pred_addr_i),
    .r_ghist_i   (ghist_o),
    .r_row_o     (pred_row_o),
    .r_taken_o   (pred_taken_o),
    .r_ghist_o   (pred_ghist_o)
  );

endmodule

// ==== test/tb_bp_predictor.sv ====
/*
 * Testbench for the branch direction predictor.
 * Runs directed tests against a reference table of counters with its own
 * global history, followed by an LFSR driven mix of lookups and updates.
 */
`timescale 1ns/1ps

module tb_bp_predictor
  import bp_pkg::*;
();

  localparam int clr_cycles      = 65;           // Reset release to init done.
  localparam int lookup_cycles   = 3;
  localparam int res_cycles      = 6;
  localparam int n_random        = 64;
  localparam int test_cycles     = clr_cycles + 150 * lookup_cycles + 20 * res_cycles
                                   + 16 + n_random * res_cycles;
  localparam int watchdog_cycles = 2 * test_cycles;
  localparam int wait_limit      = 16;           // Longest handshake wait.

  logic        clk_i, reset_i, init_done_o;
  logic        pred_v_i, pred_taken_o;
  logic [31:0] pred_addr_i, res_addr_i;
  logic [1:0]  pred_ghist_o, res_ghist_i, ghist_o;
  bp_row_u     pred_row_o, res_row_i;
  logic        res_v_i, res_correct_i, res_taken_i, res_ready_o;

  bp_row_u     model_rows [64];  // Reference table.
  logic [1:0]  model_ghist;
  bp_row_u     last_row;         // Row expected from the most recent lookup.
  logic [31:0] lfsr_r = 32'he36e15e2;

  logic [3:0]  pend_idx;         // Resolution in flight.
  logic [1:0]  pend_ghist;
  bp_row_u     pend_row;
  logic        pend_correct, pend_taken;

  bp_predictor i_bp_predictor (
    .clk_i, .reset_i, .init_done_o,
    .pred_v_i, .pred_addr_i, .pred_row_o, .pred_taken_o, .pred_ghist_o,
    .res_v_i, .res_addr_i, .res_ghist_i, .res_row_i, .res_correct_i, .res_taken_i,
    .res_ready_o, .ghist_o
  );

  initial
  begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  initial
  begin
    repeat (watchdog_cycles) @(posedge clk_i);
    stop_on_error($sformatf("Watchdog expired at %0t, the tests did not finish", $time));
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference model, stimulus helpers and checks.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1, "Simulation stopped at the first error.");
  endtask

  task automatic compare_row(input bp_row_u got, input bp_row_u exp, input string what);
    if (got.raw !== exp.raw)
      stop_on_error($sformatf("FAILED at %0t: %s is %b, expected %b",
                              $time, what, got.raw, exp.raw));
  endtask

  task automatic compare_bit(input logic got, input logic exp, input string what);
    if (got !== exp)
      stop_on_error($sformatf("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp));
  endtask

  task automatic compare_ghist(input logic [1:0] got, input logic [1:0] exp, input string what);
    if (got !== exp)
      stop_on_error($sformatf("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp));
  endtask

  task automatic compare_count(input int got, input int exp, input string what);
    if (got != exp)
      stop_on_error($sformatf("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp));
  endtask

  // A miss sets the weak bit. A weak counter that misses changes direction.
  function automatic bp_ctr_t next_ctr(input bp_ctr_t old, input logic correct);
    if (correct)
      return {old[1], 1'b0};
    return {old[1] ^ old[0], 1'b1};
  endfunction

  function automatic bp_row_u next_row(input bp_row_u old, input logic correct);
    bp_row_u upd;
    upd.ctr[0] = next_ctr(old.ctr[0], correct);
    upd.ctr[1] = next_ctr(old.ctr[1], correct);
    return upd;
  endfunction

  function automatic logic [31:0] make_addr(input logic [3:0] idx, input logic slot);
    return {25'h0, slot, idx, 2'b00};
  endfunction

  // Taps 32, 22, 2 and 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_r = lfsr_next(lfsr_r);
      val    = {val[30:0], lfsr_r[0]};
    end
  endtask

  task automatic lookup_check(input logic [31:0] addr);
    logic [5:0] idx;
    @(posedge clk_i);
    pred_v_i    <= 1'b1;
    pred_addr_i <= addr;
    idx = {addr[5:2], model_ghist};
    @(posedge clk_i);
    pred_v_i <= 1'b0;
    @(negedge clk_i);
    last_row = model_rows[idx];
    compare_row(pred_row_o, last_row, "pred_row_o");
    compare_bit(pred_taken_o, last_row.ctr[addr[6]][1], "pred_taken_o");
    compare_ghist(pred_ghist_o, model_ghist, "pred_ghist_o");
  endtask

  task automatic accept_res(input logic [31:0] addr, input logic [1:0] g, input bp_row_u row,
                            input logic correct, input logic taken);
    int waits;
    @(posedge clk_i);
    res_v_i       <= 1'b1;
    res_addr_i    <= addr;
    res_ghist_i   <= g;
    res_row_i     <= row;
    res_correct_i <= correct;
    res_taken_i   <= taken;
    pend_idx      = addr[5:2];
    pend_ghist    = g;
    pend_row      = row;
    pend_correct  = correct;
    pend_taken    = taken;
    waits         = 0;
    @(negedge clk_i);
    while (!res_ready_o)
    begin
      waits++;
      if (waits > wait_limit)
        stop_on_error("The predictor never accepted a resolution.");
      @(negedge clk_i);
    end
    @(posedge clk_i);
    res_v_i <= 1'b0;
  endtask

  // Ends once the table has taken the buffered write, then updates the model.
  task automatic wait_res_done();
    int waits;
    waits = 0;
    @(negedge clk_i);
    while (!res_ready_o)
    begin
      waits++;
      if (waits > wait_limit)
        stop_on_error("A buffered resolution was never written to the table.");
      @(negedge clk_i);
    end
    model_rows[{pend_idx, pend_ghist}] = next_row(pend_row, pend_correct);
    model_ghist = {model_ghist[0], pend_taken};
    compare_ghist(ghist_o, model_ghist, "ghist_o");
  endtask

  task automatic send_res(input logic [31:0] addr, input logic [1:0] g, input bp_row_u row,
                          input logic correct, input logic taken);
    accept_res(addr, g, row, correct, taken);
    wait_res_done();
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Directed tests.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic init_clear();
    int cycles;
    cycles = 0;
    compare_bit(res_ready_o, 1'b1, "res_ready_o after reset");
    compare_ghist(ghist_o, 2'b00, "ghist_o after reset");
    @(negedge clk_i);
    while (!init_done_o)
    begin
      cycles++;
      if (cycles > 4 * clr_cycles)
        stop_on_error("init_done_o never rose after reset.");
      @(negedge clk_i);
    end
    compare_count(cycles, clr_cycles, "cycles until init_done_o");
    for (int i = 0; i < 64; i++)
      model_rows[i[5:0]].raw = {bp_ctr_init, bp_ctr_init};
    model_ghist = 2'b00;
    // History walks 00, 01, 11, 10 and back to 00. A miss on a 00 row
    // rewrites the row just checked with its cleared value.
    for (int h = 0; h < 4; h++)
    begin
      for (int i = 0; i < 32; i++)
        lookup_check(make_addr(i[3:0], i[4]));
      send_res(make_addr(4'd0, 1'b0), model_ghist, 4'b0000, 1'b0, h < 2);
    end
  endtask

  // Every counter state meets a hit and a miss. History stays at zero.
  task automatic update_rule();
    bp_row_u row;
    for (int k = 0; k < 8; k++)
    begin
      row.raw = {k[2:1], ~k[2:1]};
      send_res(make_addr(k[3:0], k[0]), model_ghist, row, k[0], 1'b0);
      lookup_check(make_addr(k[3:0], k[0]));
    end
  endtask

  task automatic lookup_hold();
    bp_row_u held;
    lookup_check(make_addr(4'd9, 1'b1));
    held = last_row;
    send_res(make_addr(4'd9, 1'b0), model_ghist, 4'b1011, 1'b0, 1'b0);
    @(negedge clk_i);
    compare_row(pred_row_o, held, "held pred_row_o");
    compare_bit(pred_taken_o, held.ctr[1][1], "held pred_taken_o");
    lookup_check(make_addr(4'd9, 1'b1));
  endtask

  task automatic history_shift();
    send_res(make_addr(4'd10, 1'b0), model_ghist, 4'b1010, 1'b1, 1'b1);
    lookup_check(make_addr(4'd10, 1'b0));
    send_res(make_addr(4'd11, 1'b1), model_ghist, 4'b0110, 1'b0, 1'b1);
    lookup_check(make_addr(4'd10, 1'b1));
    send_res(make_addr(4'd12, 1'b0), model_ghist, 4'b1100, 1'b1, 1'b0);
    lookup_check(make_addr(4'd10, 1'b0));
  endtask

  // A lookup held on the target row blocks the write until it goes away.
  task automatic back_pressure();
    bp_row_u old_row;
    old_row = model_rows[{4'd13, model_ghist}];
    @(posedge clk_i);
    pred_v_i    <= 1'b1;
    pred_addr_i <= make_addr(4'd13, 1'b0);
    accept_res(make_addr(4'd13, 1'b1), model_ghist, 4'b1001, 1'b0, 1'b1);
    repeat (6)
    begin
      @(negedge clk_i);
      compare_bit(res_ready_o, 1'b0, "res_ready_o under conflict");
      compare_row(pred_row_o, old_row, "pred_row_o under conflict");
    end
    @(posedge clk_i);
    pred_v_i <= 1'b0;
    wait_res_done();
    // Shift the history back so the lookup reaches the blocked row.
    send_res(make_addr(4'd14, 1'b0), model_ghist, 4'b0000, 1'b1, 1'b0);
    lookup_check(make_addr(4'd13, 1'b0));
  endtask

  task automatic random_mix();
    logic [31:0] op, addr, g, row, c, t;
    for (int n = 0; n < n_random; n++)
    begin
      rand_bits(1, op);
      rand_bits(32, addr);
      if (op[0])
      begin
        lookup_check(addr);
      end
      else
      begin
        rand_bits(2, g);
        rand_bits(4, row);
        rand_bits(1, c);
        rand_bits(1, t);
        send_res(addr, g[1:0], row[3:0], c[0], t[0]);
      end
    end
  endtask

  initial
  begin
    reset_i       = 1'b1;
    pred_v_i      = 1'b0;
    pred_addr_i   = '0;
    res_v_i       = 1'b0;
    res_addr_i    = '0;
    res_ghist_i   = '0;
    res_row_i     = '0;
    res_correct_i = 1'b0;
    res_taken_i   = 1'b0;
    repeat (4) @(posedge clk_i);
    reset_i <= 1'b0;
    init_clear();
    update_rule();
    lookup_hold();
    history_shift();
    back_pressure();
    random_mix();
    $display("All tests passed!");
    $finish;
  end

endmodule

// ==== filelist.f ====
hdl/bp_pkg.sv
hdl/bht_mem.sv
hdl/bht.sv
hdl/bp_update_ctrl.sv
hdl/bp_predictor.sv
test/tb_bp_predictor.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the predictor testbench with Verilator and runs it.
# Returns a failing status when the build breaks or the testbench reports failure.

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --top-module tb_bp_predictor -f filelist.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$log" 2>&1
status=$?
cat "$log"

if grep -q "Test failures found" "$log"; then
  echo "Simulation reported failures, see $log"
  exit 1
fi

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

echo "Simulation finished without failures"
exit 0
